// ==== include/bch_defines.svh ====
// ======================================================================
// Sizes fixed for BCH(15,11) only, other codes need a new buffer map
// BCH_PIPE must be 0 or 1
// ======================================================================

`ifndef BCH_DEFINES_SVH
`define BCH_DEFINES_SVH

// Code length in bits
`define BCH_N 15

// Bit position inside one block, 0..14
`define BCH_ADDR_W 4

// Ping-pong half select
`define BCH_BNUM_W 1

// Extra register after the RAM read, adds one cycle of latency
`define BCH_PIPE 1

`endif

// ==== rtl/bch_pkg.sv ====
// ======================================================================
// Shared types of the BCH(15,11) decoder, widths come from the defines
// ======================================================================

`default_nettype none

`include "bch_defines.svh"

package bch_pkg;

  // GF(16) element, polynomial basis over x^4+x+1
  typedef logic [3:0] gf_t;

  // Coefficient index inside a block
  typedef logic [`BCH_ADDR_W-1:0] baddr_t;

  // Buffer half
  typedef logic [`BCH_BNUM_W-1:0] bptr_t;

  // Buffer write port
  typedef struct packed {
    logic   write;  // Write strobe
    baddr_t waddr;  // Coefficient index
    bptr_t  wptr;   // Half being filled
    logic   wdata;  // Received bit
  } buf_wr_s;

  // Buffer read port
  typedef struct packed {
    logic   read;   // Read strobe
    baddr_t raddr;  // Coefficient index
    bptr_t  rptr;   // Half being drained
  } buf_rd_s;

  // Read-out sequencer
  typedef enum logic {
    ST_IDLE,
    ST_READ
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== rtl/bch_dec_ctrl.sv ====
// ======================================================================
// Block of 15 strobes expected, isop restarts the count at position 14
// A new block end during read-out restarts the read of the new half
// ======================================================================

`default_nettype none

`include "bch_defines.svh"

module bch_dec_ctrl (
  input  logic             iclk,
  input  logic             rst_n,
  input  logic             iclkena,
  input  logic             ival,
  input  logic             isop,
  input  logic             ibit,
  output bch_pkg::buf_wr_s wr,
  output bch_pkg::buf_rd_s rd,
  output logic             blk_end
);

  // Highest coefficient index, first on the wire
  localparam bch_pkg::baddr_t LAST_POS = bch_pkg::baddr_t'(`BCH_N - 1);
  localparam bch_pkg::baddr_t ONE_POS  = bch_pkg::baddr_t'(1);

  bch_pkg::baddr_t      wcnt;   // Next write position
  bch_pkg::bptr_t       wptr;   // Half being filled
  bch_pkg::baddr_t      rcnt;   // Current read position
  bch_pkg::bptr_t       rptr;   // Half being drained
  bch_pkg::ctrl_state_e state;

  // ====================================================================
  // Write side
  // ====================================================================

  assign wr = '{
    write: ival,
    waddr: (isop ? LAST_POS : wcnt),  // Sop forces position 14
    wptr:  wptr,
    wdata: ibit
  };

  // Last coefficient of the block goes in now
  assign blk_end = wr.write & (wr.waddr == '0);

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      wcnt <= LAST_POS;
      wptr <= '0;
    end else if (iclkena && wr.write) begin
      if (blk_end) begin
        wcnt <= LAST_POS;     // Ready for next block
        wptr <= ~wptr;        // Swap halves
      end else begin
        wcnt <= wr.waddr - ONE_POS;
      end
    end
  end

  // ====================================================================
  // Read-out sequencer
  // ====================================================================

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= bch_pkg::ST_IDLE;
      rcnt  <= LAST_POS;
      rptr  <= '0;
    end else if (iclkena) begin
      if (blk_end) begin
        // Drain the half just written, wins over a read in progress
        state <= bch_pkg::ST_READ;
        rcnt  <= LAST_POS;
        rptr  <= wptr;
      end else begin
        case (state)
          bch_pkg::ST_IDLE: rcnt <= LAST_POS;
          bch_pkg::ST_READ: begin
            if (rcnt == '0) begin
              state <= bch_pkg::ST_IDLE;  // Position 0 read, done
            end else begin
              rcnt <= rcnt - ONE_POS;
            end
          end
          default: state <= bch_pkg::ST_IDLE;
        endcase
      end
    end
  end

  assign rd = '{
    read:  (state == bch_pkg::ST_READ),
    raddr: rcnt,
    rptr:  rptr
  };

endmodule

`default_nettype wire

// ==== rtl/bch_syndrome.sv ====
// ======================================================================
// Single syndrome S1 = r(alpha), enough for t=1 only
// syn holds until the next block end
// ======================================================================

`default_nettype none

`include "bch_defines.svh"

module bch_syndrome (
  input  logic             iclk,
  input  logic             rst_n,
  input  logic             iclkena,
  input  bch_pkg::buf_wr_s wr,
  input  logic             blk_end,
  output bch_pkg::gf_t     syn
);

  localparam bch_pkg::baddr_t LAST_POS = bch_pkg::baddr_t'(`BCH_N - 1);

  // a * alpha mod x^4+x+1
  function automatic bch_pkg::gf_t mul_alpha(input bch_pkg::gf_t a);
    return {a[2], a[1], a[0] ^ a[3], a[3]};
  endfunction

  logic         first;    // First coefficient of a block
  bch_pkg::gf_t base;     // Horner term before adding the bit
  bch_pkg::gf_t acc;      // Running partial evaluation
  bch_pkg::gf_t acc_nxt;

  assign first   = (wr.waddr == LAST_POS);
  assign base    = first ? '0 : mul_alpha(acc);   // Restart on new block
  assign acc_nxt = base ^ {3'b000, wr.wdata};

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
      syn <= '0;
    end else if (iclkena && wr.write) begin
      acc <= acc_nxt;
      if (blk_end) begin
        syn <= acc_nxt;   // alpha^j for one error at j, else zero
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bch_buffer.sv ====
// ======================================================================
// No read/write collision check, ping-pong keeps the halves apart
// Read latency is 1 + BCH_PIPE enabled cycles
// ======================================================================

`default_nettype none

`include "bch_defines.svh"

module bch_buffer (
  input  logic             iclk,
  input  logic             iclkena,
  input  bch_pkg::buf_wr_s wr,
  input  bch_pkg::buf_rd_s rd,
  output logic             rdata
);

  localparam int RAM_AW = `BCH_ADDR_W + `BCH_BNUM_W;

  logic              ram      [2**RAM_AW];  // Both halves
  logic              ram_pipe [2];          // Read registers
  logic [RAM_AW-1:0] ram_waddr;
  logic [RAM_AW-1:0] ram_raddr;

  // Half select is the address MSB
  assign ram_waddr = {wr.wptr, wr.waddr};
  assign ram_raddr = {rd.rptr, rd.raddr};

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (wr.write) begin
        ram[ram_waddr] <= wr.wdata;
      end
      if (rd.read) begin
        ram_pipe[0] <= ram[ram_raddr];
      end
      ram_pipe[1] <= ram_pipe[0];   // Optional second stage
    end
  end

  assign rdata = ram_pipe[`BCH_PIPE];

endmodule

`default_nettype wire

// ==== rtl/bch_err_locator.sv ====
// ======================================================================
// Expects reads from position 14 down to 0 on consecutive enabled cycles
// Double errors give a wrong flip, not detected
// ======================================================================

`default_nettype none

`include "bch_defines.svh"

module bch_err_locator (
  input  logic             iclk,
  input  logic             rst_n,
  input  logic             iclkena,
  input  bch_pkg::buf_rd_s rd,
  input  bch_pkg::gf_t     syn,
  input  logic             rdata,
  output logic             oval,
  output logic             osop,
  output logic             obit,
  output logic             oerr
);

  localparam int              LAT      = 1 + `BCH_PIPE;  // Buffer latency
  localparam bch_pkg::baddr_t LAST_POS = bch_pkg::baddr_t'(`BCH_N - 1);
  localparam bch_pkg::gf_t    ALPHA_14 = 4'b1001;        // alpha^14 = alpha^3 + 1

  // Control bits riding alongside the RAM read
  typedef struct packed {
    logic val;
    logic sop;
    logic flip;
    logic nz;
  } tag_s;

  // a * alpha^-1 mod x^4+x+1
  function automatic bch_pkg::gf_t mul_alpha_inv(input bch_pkg::gf_t a);
    return {a[0], a[3], a[2], a[1] ^ a[0]};
  endfunction

  logic         first;
  bch_pkg::gf_t pw;       // alpha^raddr for the next read
  bch_pkg::gf_t cur;      // Power for this read
  tag_s         tag;
  tag_s         dly [LAT];
  tag_s         last;

  assign first = rd.read & (rd.raddr == LAST_POS);
  assign cur   = first ? ALPHA_14 : pw;

  // Powers are never zero, so a zero syndrome never matches
  assign tag = '{val: rd.read, sop: first, flip: rd.read & (cur == syn), nz: (syn != '0)};

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      pw <= ALPHA_14;
    end else if (iclkena && rd.read) begin
      pw <= mul_alpha_inv(cur);   // Step one position down
    end
  end

  // ====================================================================
  // Align flags with rdata, then register the outputs
  // ====================================================================

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < LAT; k++) begin
        dly[k] <= '0;
      end
    end else if (iclkena) begin
      dly[0] <= tag;
      for (int k = 1; k < LAT; k++) begin
        dly[k] <= dly[k-1];
      end
    end
  end

  assign last = dly[LAT-1];

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      oval <= 1'b0;
      osop <= 1'b0;
      oerr <= 1'b0;
    end else if (iclkena) begin
      oval <= last.val;
      osop <= last.sop;
      oerr <= last.val & last.nz;   // Correction applied in this block
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      obit <= rdata ^ last.flip;    // Flip the located bit
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bch_dec_top.sv ====
// ======================================================================
// No handshake, iclkena low stalls everything, block latency 2+BCH_PIPE
// ======================================================================

`default_nettype none

module bch_dec_top (
  input  logic iclk,
  input  logic rst_n,
  input  logic iclkena,
  input  logic ival,
  input  logic isop,
  input  logic ibit,
  output logic oval,
  output logic osop,
  output logic obit,
  output logic oerr
);

  bch_pkg::buf_wr_s wr;       // Write port, also feeds syndrome
  bch_pkg::buf_rd_s rd;       // Read port, also feeds locator
  logic             blk_end;
  bch_pkg::gf_t     syn;
  logic             rdata;

  // ====================================================================
  // Write counter and read sequencer
  // ====================================================================

  bch_dec_ctrl u_ctrl (
    .iclk    (iclk),
    .rst_n   (rst_n),
    .iclkena (iclkena),
    .ival    (ival),
    .isop    (isop),
    .ibit    (ibit),
    .wr      (wr),
    .rd      (rd),
    .blk_end (blk_end)
  );

  bch_syndrome u_syndrome (
    .iclk    (iclk),
    .rst_n   (rst_n),
    .iclkena (iclkena),
    .wr      (wr),
    .blk_end (blk_end),
    .syn     (syn)
  );

  // Ping-pong codeword store
  bch_buffer u_buffer (
    .iclk    (iclk),
    .iclkena (iclkena),
    .wr      (wr),
    .rd      (rd),
    .rdata   (rdata)
  );

  bch_err_locator u_locator (
    .iclk    (iclk),
    .rst_n   (rst_n),
    .iclkena (iclkena),
    .rd      (rd),
    .syn     (syn),
    .rdata   (rdata),
    .oval    (oval),
    .osop    (osop),
    .obit    (obit),
    .oerr    (oerr)
  );

endmodule

`default_nettype wire

// ==== dv/bch_clk_gen.sv ====
// ======================================================================
// Free-running clock, period 10, starts low
// ======================================================================

`default_nettype none

module bch_clk_gen (
  output logic iclk
);

  localparam int HALF = 5;  // Half period

  initial begin
    iclk = 1'b0;
    forever #HALF iclk = ~iclk;
  end

endmodule

`default_nettype wire

// ==== dv/bch_dec_asserts.sv ====
// ======================================================================
// Framing checks only, data is left to the testbench
// Expects isop on every 15th accepted input strobe
// ======================================================================

`default_nettype none

`include "bch_defines.svh"

module bch_dec_asserts (
  input logic iclk,
  input logic rst_n,
  input logic iclkena,
  input logic ival,
  input logic isop,
  input logic oval,
  input logic osop
);

  localparam logic [3:0] LAST_IN = 4'(`BCH_N - 1);

  logic [3:0] out_cnt;       // Bits of the current output block so far
  logic [3:0] in_cnt;        // Input position, 0 at block start
  int         fail_cnt = 0;  // Assertion failures so far

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt <= '0;
      in_cnt  <= '0;
    end else if (iclkena) begin
      if (oval) begin
        out_cnt <= osop ? 4'd1 : out_cnt + 4'd1;  // Sop restarts the count
      end
      if (ival) begin
        in_cnt <= (in_cnt == LAST_IN) ? '0 : in_cnt + 4'd1;
      end
    end
  end

  // ====================================================================
  // Output framing
  // ====================================================================

  a_sop_with_val: assert property (@(posedge iclk) disable iff (!rst_n)
    osop |-> oval)
    else begin
      $error("osop without oval");
      fail_cnt++;
    end

  a_sop_at_boundary: assert property (@(posedge iclk) disable iff (!rst_n)
    (iclkena && osop) |-> (out_cnt == 4'd0 || out_cnt == 4'(`BCH_N)))
    else begin
      $error("osop before the previous block finished");
      fail_cnt++;
    end

  // Bits without sop belong to an open block
  a_bit_in_block: assert property (@(posedge iclk) disable iff (!rst_n)
    (iclkena && oval && !osop) |-> (out_cnt inside {[4'd1:LAST_IN]}))
    else begin
      $error("oval outside a block");
      fail_cnt++;
    end

  a_no_gap: assert property (@(posedge iclk) disable iff (!rst_n)
    (iclkena && (out_cnt inside {[4'd1:LAST_IN]})) |-> oval)
    else begin
      $error("gap in oval inside a block");
      fail_cnt++;
    end

  // Input side, sop exactly on position 14
  a_in_sop_pos: assert property (@(posedge iclk) disable iff (!rst_n)
    (iclkena && ival) |-> (isop == (in_cnt == 4'd0)))
    else begin
      $error("isop not on the first strobe of a block");
      fail_cnt++;
    end

endmodule

bind bch_dec_top bch_dec_asserts u_asserts (
  .iclk    (iclk),
  .rst_n   (rst_n),
  .iclkena (iclkena),
  .ival    (ival),
  .isop    (isop),
  .oval    (oval),
  .osop    (osop)
);

`default_nettype wire

// ==== dv/bch_dec_tb.sv ====
// ======================================================================
// Reads dv/bch_stim.txt from the project root, at most 32 blocks
// First 8 blocks back to back, later ones get gaps and enable drops
// ======================================================================

`default_nettype none

`include "bch_defines.svh"

module bch_dec_tb;

  localparam int MAX_LINES = 32;
  localparam int BB_LINES  = 8;              // Leading blocks without gaps
  localparam int MAX_GAP   = 3;              // Idle cycles before a strobe, at most
  localparam int LATENCY   = 2 + `BCH_PIPE;  // Last input to first output

  logic iclk;
  logic rst_n;
  logic iclkena;
  logic ival;
  logic isop;
  logic ibit;
  logic oval;
  logic osop;
  logic obit;
  logic oerr;

  logic [15:0] stim_mem [3*MAX_LINES];  // Codeword, mask, expected per line
  int          n_lines;
  logic        stim_ready;
  logic        last_bit;                // Strobe on the bus is position 0
  logic        en_at_edge  = 1'b0;      // iclkena at the last rising edge
  int          since_last  = 1000;      // Enabled edges since a last input bit

  // Collector state
  logic        in_block    = 1'b0;
  int          bit_cnt     = 0;
  logic [14:0] got_word    = '0;
  logic        got_err     = 1'b0;
  int          done_blocks = 0;
  int          errors      = 0;

  bch_clk_gen u_clk (.iclk(iclk));

  bch_dec_top uut (
    .iclk    (iclk),
    .rst_n   (rst_n),
    .iclkena (iclkena),
    .ival    (ival),
    .isop    (isop),
    .ibit    (ibit),
    .oval    (oval),
    .osop    (osop),
    .obit    (obit),
    .oerr    (oerr)
  );

  // Drops about one cycle in eight when random
  function automatic logic pick_enable(input logic random_mode);
    if (!random_mode) begin
      return 1'b1;
    end
    return ($urandom_range(7, 0) != 0);
  endfunction

  task automatic idle_cycle(input logic random_mode);
    @(negedge iclk);
    ival     = 1'b0;
    isop     = 1'b0;
    last_bit = 1'b0;
    iclkena  = pick_enable(random_mode);
  endtask

  // Strobe held until an enabled edge takes it
  task automatic drive_bit(input logic b, input logic sop, input logic last,
                           input logic random_mode);
    do begin
      @(negedge iclk);
      ival     = 1'b1;
      isop     = sop;
      ibit     = b;
      last_bit = last;
      iclkena  = pick_enable(random_mode);
      @(posedge iclk);
    end while (!iclkena);
  endtask

  task automatic send_block(input logic [14:0] word, input logic random_mode);
    int gap;
    for (int pos = `BCH_N - 1; pos >= 0; pos--) begin   // Coefficient 14 first
      gap = random_mode ? int'($urandom_range(MAX_GAP, 0)) : 0;
      repeat (gap) idle_cycle(random_mode);
      drive_bit(word[pos], pos == `BCH_N - 1, pos == 0, random_mode);
    end
  endtask

  // Compare one collected block with its stim line
  task automatic close_block(input logic [14:0] word, input logic err);
    logic [14:0] exp_word;
    logic        exp_err;
    logic        ok;
    ok = 1'b1;
    if (done_blocks >= n_lines) begin
      $display("Unexpected extra output block at %0t", $time);
      errors++;
    end else begin
      exp_word = stim_mem[3*done_blocks+2][14:0];
      exp_err  = (stim_mem[3*done_blocks+1] != 16'h0000);   // Any error injected
      assert (word == exp_word) else begin
        $display("Error at %0t: block %0d word %h, expected %h",
                 $time, done_blocks, word, exp_word);
        errors++;
        ok = 1'b0;
      end
      assert (err == exp_err) else begin
        $display("Error at %0t: block %0d oerr %b, expected %b",
                 $time, done_blocks, err, exp_err);
        errors++;
        ok = 1'b0;
      end
      $display("block %0d: %s, word %h oerr %b", done_blocks, ok ? "ok" : "bad", word, err);
    end
    done_blocks++;
  endtask

  // ====================================================================
  // Edge bookkeeping and output collector
  // ====================================================================

  always @(posedge iclk) begin
    en_at_edge <= iclkena;
    if (iclkena) begin
      if (ival && last_bit) begin
        since_last <= 0;                 // Block end sampled here
      end else if (since_last < 1000) begin
        since_last <= since_last + 1;
      end
    end
  end

  // Outputs are stable at the falling edge, new only after an enabled rise
  always @(negedge iclk) begin
    if (rst_n && en_at_edge) begin
      if (osop) begin
        assert (!in_block) else begin
          $display("Framing problem at %0t: osop inside block %0d", $time, done_blocks);
          errors++;
        end
        assert (since_last == LATENCY) else begin
          $display("Error at %0t: first bit %0d enabled edges after last input, expected %0d",
                   $time, since_last, LATENCY);
          errors++;
        end
        in_block = 1'b1;
        bit_cnt  = 0;
        got_err  = oerr;                 // Valid with osop only
      end
      if (in_block) begin
        assert (oval) else begin
          $display("Framing problem at %0t: oval dropped inside block %0d",
                   $time, done_blocks);
          errors++;
        end
        got_word = {got_word[13:0], obit};
        bit_cnt++;
        if (bit_cnt == `BCH_N) begin
          in_block = 1'b0;
          close_block(got_word, got_err);
        end
      end else begin
        assert (!oval) else begin
          $display("Framing problem at %0t: oval without osop", $time);
          errors++;
        end
      end
    end
  end

  // Limit scales with block count and worst gap
  initial begin
    wait (stim_ready);
    repeat (n_lines * (`BCH_N + MAX_GAP) * 4 + 200) @(posedge iclk);
    $display("Timeout: %0d of %0d blocks seen in time", done_blocks, n_lines);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_n      = 1'b0;
    iclkena    = 1'b1;
    ival       = 1'b0;
    isop       = 1'b0;
    ibit       = 1'b0;
    last_bit   = 1'b0;
    n_lines    = 0;
    stim_ready = 1'b0;
    void'($urandom(32'h6fee_0c37));
    for (int i = 0; i < 3*MAX_LINES; i++) begin
      stim_mem[i] = 16'hffff;            // Never a 15-bit codeword
    end
    $readmemh("dv/bch_stim.txt", stim_mem);
    for (int i = 0; i < MAX_LINES; i++) begin
      if (stim_mem[3*i] != 16'hffff) begin
        n_lines = i + 1;
      end
    end
    stim_ready = 1'b1;
    if (n_lines == 0) begin
      $display("No stimulus lines read from dv/bch_stim.txt");
      $display("Test failed");
    end else begin
      repeat (8) @(negedge iclk);
      rst_n = 1'b1;
      for (int i = 0; i < n_lines; i++) begin
        send_block(15'(stim_mem[3*i] ^ stim_mem[3*i+1]), i >= BB_LINES);
      end
      @(negedge iclk);
      ival     = 1'b0;
      isop     = 1'b0;
      last_bit = 1'b0;
      iclkena  = 1'b1;                   // Let the last block drain
      wait (done_blocks >= n_lines);
      repeat (2 * `BCH_N) @(negedge iclk);  // Room for stray outputs
      if (uut.u_asserts.fail_cnt != 0) begin
        $display("Framing assertions failed %0d times", uut.u_asserts.fail_cnt);
        errors += uut.u_asserts.fail_cnt;
      end
      $display("%0d of %0d blocks checked, %0d errors", done_blocks, n_lines, errors);
      if (errors == 0) begin
        $display("Test passed");
      end else begin
        $display("Test failed");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/bch_stim.txt ====
// Columns in hex: sent codeword, error mask, expected decoded word
// Bit 14 of each word is sent first
0000 0000 0000
7fff 0000 7fff
4c13 0001 4c13
0013 0002 0013
7fff 0004 7fff
0035 0008 0035
0098 0010 0098
4c00 0020 4c00
0260 0040 0260
4c8b 0080 4c8b
7fca 0100 7fca
4e60 0200 4e60
0000 0400 0000
7fff 0800 7fff
4c13 1000 4c13
0013 2000 0013
0035 4000 0035
4c8b 0000 4c8b

// ==== vlog.f ====
+incdir+include
rtl/bch_pkg.sv
rtl/bch_dec_ctrl.sv
rtl/bch_syndrome.sv
rtl/bch_buffer.sv
rtl/bch_err_locator.sv
rtl/bch_dec_top.sv
dv/bch_clk_gen.sv
dv/bch_dec_asserts.sv
dv/bch_dec_tb.sv

// ==== Makefile ====
# Verilator build and run of the BCH(15,11) decoder testbench

VERILATOR ?= verilator
TOP       ?= bch_dec_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
